// File: sim.f
+incdir+tests
common/mem_map_pkg.sv
common/lsu_pkg.sv
rtl/mem_access_ctrl.sv
rtl/store_aligner.sv
data_memory/data_ram.sv
rtl/load_extender.sv
rtl/mem_stage_top.sv
tests/tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the memory stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_stage -f sim.f

output=$(./obj_dir/Vtb_mem_stage)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

// File: tests/tb_mem_cases.svh
    // one table row, the request fields followed by the expected response
    typedef struct packed {
        logic        write;
        logic [2:0]  mode;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        trigger;
        logic        exp_mis;
        logic [31:0] exp_rdata;
        logic        ref_only;     // rdata checked against the byte model only
    } row_t;

    localparam logic [2:0] M_BAD0   = 3'd0;
    localparam logic [2:0] M_WORD   = 3'd1;
    localparam logic [2:0] M_HALF   = 3'd2;
    localparam logic [2:0] M_BYTE   = 3'd3;
    localparam logic [2:0] M_HALF_U = 3'd4;
    localparam logic [2:0] M_BYTE_U = 3'd5;
    localparam logic [2:0] M_BAD6   = 3'd6;

    // columns: name, write, mode, addr, wdata, trigger, exp misaligned, exp rdata
    task automatic load_cases();
        add_case("st_w200",  1'b1, M_WORD,   32'h0000_0200, 32'hf1e2_83a4, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_w200",  1'b0, M_WORD,   32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0, 32'hf1e2_83a4);
        add_case("ld_h200",  1'b0, M_HALF,   32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_83a4);
        add_case("ld_hu200", 1'b0, M_HALF_U, 32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_83a4);
        add_case("ld_h202",  1'b0, M_HALF,   32'h0000_0202, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_f1e2);
        add_case("ld_hu202", 1'b0, M_HALF_U, 32'h0000_0202, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_f1e2);
        add_case("ld_b200",  1'b0, M_BYTE,   32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_ffa4);
        add_case("ld_bu200", 1'b0, M_BYTE_U, 32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00a4);
        add_case("ld_b201",  1'b0, M_BYTE,   32'h0000_0201, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_ff83);
        add_case("ld_bu201", 1'b0, M_BYTE_U, 32'h0000_0201, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0083);
        add_case("ld_b202",  1'b0, M_BYTE,   32'h0000_0202, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_ffe2);
        add_case("ld_bu202", 1'b0, M_BYTE_U, 32'h0000_0202, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00e2);
        add_case("ld_b203",  1'b0, M_BYTE,   32'h0000_0203, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_fff1);
        add_case("ld_bu203", 1'b0, M_BYTE_U, 32'h0000_0203, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00f1);
        add_case("st_w204",  1'b1, M_WORD,   32'h0000_0204, 32'h1234_5678, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_h204",  1'b0, M_HALF,   32'h0000_0204, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_5678);
        add_case("ld_b207",  1'b0, M_BYTE,   32'h0000_0207, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0012);
        // partial stores keep the neighbouring lanes
        add_case("st_w208",  1'b1, M_WORD,   32'h0000_0208, 32'haabb_ccdd, 1'b0, 1'b0, 32'h0000_0000);
        add_case("st_b209",  1'b1, M_BYTE,   32'h0000_0209, 32'hffff_ff11, 1'b0, 1'b0, 32'h0000_0000);
        add_case("st_h20a",  1'b1, M_HALF,   32'h0000_020a, 32'h1234_5566, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_w208a", 1'b0, M_WORD,   32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h5566_11dd);
        add_case("st_bu208", 1'b1, M_BYTE_U, 32'h0000_0208, 32'h0000_007f, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_w208b", 1'b0, M_WORD,   32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h5566_117f);
        // misaligned and invalid accesses change nothing
        add_case("st_w20a",  1'b1, M_WORD,   32'h0000_020a, 32'hdead_beef, 1'b0, 1'b1, 32'h0000_0000);
        add_case("st_h209",  1'b1, M_HALF,   32'h0000_0209, 32'h0000_beef, 1'b0, 1'b1, 32'h0000_0000);
        add_case("ld_w201",  1'b0, M_WORD,   32'h0000_0201, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000);
        add_case("ld_hu203", 1'b0, M_HALF_U, 32'h0000_0203, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000);
        add_case("ld_w208c", 1'b0, M_WORD,   32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h5566_117f);
        add_case("st_m0",    1'b1, M_BAD0,   32'h0000_0208, 32'hffff_ffff, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_m6",    1'b0, M_BAD6,   32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_w208d", 1'b0, M_WORD,   32'h0000_0208, 32'h0000_0000, 1'b0, 1'b0, 32'h5566_117f);
        // status word, the RAM word at index 64 is reached through an alias
        add_case("st_w20100", 1'b1, M_WORD,  32'h0002_0100, 32'hcafe_0001, 1'b0, 1'b0, 32'h0000_0000);
        add_case("st_w100",  1'b1, M_WORD,   32'h0000_0100, 32'h1234_5678, 1'b1, 1'b0, 32'h0000_0000);
        add_case("ld_w20100", 1'b0, M_WORD,  32'h0002_0100, 32'h0000_0000, 1'b1, 1'b0, 32'hcafe_0001);
        add_case("ld_w100a", 1'b0, M_WORD,   32'h0000_0100, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0001);
        add_case("ld_w100b", 1'b0, M_WORD,   32'h0000_0100, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000);
        add_case("ld_b100",  1'b0, M_BYTE,   32'h0000_0100, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0001);
        add_case("ld_hu100", 1'b0, M_HALF_U, 32'h0000_0100, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000);
    endtask

// File: tests/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int FILL_LEN = 32;               // words in the fill test

    logic              clk = 1'b0;
    logic              reset;
    lsu_pkg::mem_req_t req;
    logic              trigger;
    lsu_pkg::mem_rsp_t rsp;

    `include "tb_mem_cases.svh"

    row_t       rows[$];
    string      names[$];
    logic [7:0] ref_mem [int];                  // byte model keyed by address bits 16..0
    int         num_cases;
    int         cycle_count = 0;
    int         timeout_limit;
    int         test_errors;
    int         pass_count = 0;
    int         fail_count = 0;

    mem_stage_top i_mem_stage_top (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .trigger (trigger),
        .rsp     (rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic add_case(input string name, input logic write, input logic [2:0] mode,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic trig, input logic exp_mis,
                            input logic [31:0] exp_rdata);
        names.push_back(name);
        rows.push_back({write, mode, addr, wdata, trig, exp_mis, exp_rdata, 1'b0});
    endtask

    function automatic int access_size(input logic [2:0] mode);
        int size;
        if (mode == M_WORD)
            size = 4;
        else if (mode == M_HALF || mode == M_HALF_U)
            size = 2;
        else
            size = 1;
        return size;
    endfunction

    // valid mode, aligned, and not the status word
    function automatic logic reaches_ram(input row_t r);
        return (r.mode >= M_WORD) && (r.mode <= M_BYTE_U)
               && (r.addr % access_size(r.mode) == 0) && (r.addr != 32'h0000_0100);
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int key;
        key = int'(addr & 32'h0001_fffc);
        return {ref_mem[key + 3], ref_mem[key + 2], ref_mem[key + 1], ref_mem[key]};
    endfunction

    task automatic update_ref(input row_t r);
        int key;
        key = int'(r.addr & 32'h0001_ffff);
        for (int i = 0; i < access_size(r.mode); i++)
            ref_mem[key + i] = r.wdata[8*i +: 8];   // lowest byte at the lowest address
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic build_fill();
        logic [31:0] addr;
        logic [31:0] fill_addr [FILL_LEN];
        for (int i = 0; i < FILL_LEN; i++)
        begin
            addr = $urandom & 32'h0001_fffc;
            if (addr == 32'h0000_0100)
                addr = 32'h0000_0104;          // keep clear of the status word
            fill_addr[i] = addr;
            add_case($sformatf("fill_st%0d", i), 1'b1, M_WORD, addr, $urandom, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < FILL_LEN; i++)
        begin
            add_case($sformatf("fill_ld%0d", i), 1'b0, M_WORD, fill_addr[i], '0, 1'b0, 1'b0, '0);
            rows[rows.size() - 1].ref_only = 1'b1;
        end
    endtask

    task automatic drive_row(input row_t r);
        req.valid = 1'b1;
        req.write = r.write;
        req.mode  = r.mode;
        req.addr  = r.addr;
        req.wdata = r.wdata;
        trigger   = r.trigger;
    endtask

    task automatic check_response(input int idx);
        row_t r;
        r = rows[idx];
        test_errors = 0;
        if (rsp.valid !== 1'b1)
        begin
            $display("error: no response one cycle after request %s", names[idx]);
            test_errors++;
        end
        else
        begin
            check_value({names[idx], " write"}, 32'(r.write), 32'(rsp.write));
            check_value({names[idx], " misaligned"}, 32'(r.exp_mis), 32'(rsp.misaligned));
            if (!r.ref_only)
                check_value({names[idx], " rdata"}, r.exp_rdata, rsp.rdata);
            if (r.write && reaches_ram(r))
                update_ref(r);
            else if (!r.write && r.mode == M_WORD && reaches_ram(r))
                check_value({names[idx], " model"}, ref_word(r.addr), rsp.rdata);
        end
        if (test_errors == 0)
        begin
            pass_count++;
            $display("test %s ok", names[idx]);
        end
        else
        begin
            fail_count++;
            $display("test %s had %0d mismatches", names[idx], test_errors);
        end
    endtask

    initial
    begin
        req     = '0;
        trigger = 1'b0;
        reset   = 1'b1;
        void'($urandom(32'hb4c7_3e63));
        load_cases();
        num_cases = rows.size();
        build_fill();
        timeout_limit = (num_cases + 2 * FILL_LEN) * 2 + 100;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // one request per cycle with each response checked a cycle later
        for (int i = 0; i <= rows.size(); i++)
        begin
            @(negedge clk);
            if (i > 0)
                check_response(i - 1);
            if (i < rows.size())
                drive_row(rows[i]);
            else
                req = '0;
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top
(
    input  logic              clk,
    input  logic              reset,
    input  lsu_pkg::mem_req_t req,
    input  logic              trigger,
    output lsu_pkg::mem_rsp_t rsp
);

    logic                    ram_we;
    logic                    ram_re;
    mem_map_pkg::ram_index_t ram_index;
    lsu_pkg::mode_t          st_mode;
    logic [1:0]              st_offset;
    mem_map_pkg::word_t      st_wdata;
    lsu_pkg::rsp_ctx_t       ctx;
    mem_map_pkg::byte_en_t   byte_en;
    mem_map_pkg::word_t      lane_data;
    mem_map_pkg::word_t      rd_word;

    mem_access_ctrl i_mem_access_ctrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .trigger   (trigger),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_index (ram_index),
        .st_mode   (st_mode),
        .st_offset (st_offset),
        .st_wdata  (st_wdata),
        .ctx       (ctx)
    );

    store_aligner i_store_aligner (
        .st_mode   (st_mode),
        .st_offset (st_offset),
        .st_wdata  (st_wdata),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .we      (ram_we),
        .re      (ram_re),
        .index   (ram_index),
        .byte_en (byte_en),
        .wdata   (lane_data),
        .rd_word (rd_word)
    );

    load_extender i_load_extender (
        .ctx     (ctx),
        .rd_word (rd_word),
        .rsp     (rsp)
    );

endmodule

// File: rtl/load_extender.sv
`timescale 1ns/1ps

module load_extender
(
    input  lsu_pkg::rsp_ctx_t  ctx,
    input  mem_map_pkg::word_t rd_word,
    output lsu_pkg::mem_rsp_t  rsp
);

    logic [7:0]         lane8;
    logic [15:0]        lane16;
    logic               mode_ok;
    mem_map_pkg::word_t load_data;

    assign lane8  = rd_word[{ctx.offset, 3'b000} +: 8];          // byte at the offset
    assign lane16 = rd_word[{ctx.offset[1], 4'b0000} +: 16];     // half at offset 0 or 2

    always_comb
    begin
        mode_ok   = 1'b1;
        load_data = '0;
        case (ctx.mode)
            lsu_pkg::MODE_WORD:
                load_data = rd_word;
            lsu_pkg::MODE_HALF:
                load_data = {{16{lane16[15]}}, lane16};
            lsu_pkg::MODE_HALF_U:
                load_data = {16'b0, lane16};
            lsu_pkg::MODE_BYTE:
                load_data = {{24{lane8[7]}}, lane8};
            lsu_pkg::MODE_BYTE_U:
                load_data = {24'b0, lane8};
            default:
                mode_ok = 1'b0;
        endcase
    end

    assign rsp.valid      = ctx.valid;
    assign rsp.write      = ctx.write;
    assign rsp.misaligned = ctx.misaligned;

    always_comb
    begin
        if (ctx.write || ctx.misaligned || !mode_ok)
            rsp.rdata = '0;                         // nothing to return
        else if (ctx.status_hit)
            rsp.rdata = {31'b0, ctx.trigger};       // status word
        else
            rsp.rdata = load_data;
    end

endmodule

// File: data_memory/data_ram.sv
`timescale 1ns/1ps

module data_ram
(
    input  logic                    clk,
    input  logic                    we,
    input  logic                    re,
    input  mem_map_pkg::ram_index_t index,
    input  mem_map_pkg::byte_en_t   byte_en,
    input  mem_map_pkg::word_t      wdata,
    output mem_map_pkg::word_t      rd_word
);

    mem_map_pkg::word_t mem [mem_map_pkg::RAM_WORDS];

    // byte-enabled write, lane i is address offset i
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            for (int i = 0; i < mem_map_pkg::BYTES_PER_WORD; i++)
            begin
                if (byte_en[i])
                    mem[index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // registered read, returns old data on a collision
    always_ff @(posedge clk)
    begin
        if (re)
            rd_word <= mem[index];
    end

    // the aligner and the write gate together never issue an empty write
    a_we_has_lanes: assert property (@(posedge clk)
        we |-> (byte_en != '0));

endmodule

// File: rtl/store_aligner.sv
`timescale 1ns/1ps

module store_aligner
(
    input  lsu_pkg::mode_t        st_mode,
    input  logic [1:0]            st_offset,
    input  mem_map_pkg::word_t    st_wdata,
    output mem_map_pkg::byte_en_t byte_en,
    output mem_map_pkg::word_t    lane_data
);

    // low bytes of the store data are replicated over the lanes, enables pick the target
    always_comb
    begin
        byte_en   = '0;
        lane_data = '0;
        case (st_mode)
            lsu_pkg::MODE_WORD:
            begin
                byte_en   = 4'b1111;
                lane_data = st_wdata;
            end
            lsu_pkg::MODE_HALF, lsu_pkg::MODE_HALF_U:
            begin
                byte_en   = 4'b0011 << st_offset;   // offset 0 or 2 when aligned
                lane_data = {2{st_wdata[15:0]}};
            end
            lsu_pkg::MODE_BYTE, lsu_pkg::MODE_BYTE_U:
            begin
                byte_en   = 4'b0001 << st_offset;
                lane_data = {4{st_wdata[7:0]}};
            end
            default:
            begin
                byte_en   = '0;                     // invalid mode stores nothing
                lane_data = '0;
            end
        endcase
    end

endmodule

// File: rtl/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl
(
    input  logic                    clk,
    input  logic                    reset,
    input  lsu_pkg::mem_req_t       req,
    input  logic                    trigger,
    output logic                    ram_we,
    output logic                    ram_re,
    output mem_map_pkg::ram_index_t ram_index,
    output lsu_pkg::mode_t          st_mode,
    output logic [1:0]              st_offset,
    output mem_map_pkg::word_t      st_wdata,
    output lsu_pkg::rsp_ctx_t       ctx
);

    logic              mode_ok;
    logic              misaligned;
    logic              status_hit;
    logic              access_ok;
    lsu_pkg::rsp_ctx_t ctx_next;

    // size decode and alignment check
    always_comb
    begin
        mode_ok    = 1'b1;
        misaligned = 1'b0;
        case (req.mode)
            lsu_pkg::MODE_WORD:
                misaligned = (req.addr[1:0] != 2'b00);
            lsu_pkg::MODE_HALF, lsu_pkg::MODE_HALF_U:
                misaligned = req.addr[0];
            lsu_pkg::MODE_BYTE, lsu_pkg::MODE_BYTE_U:
                misaligned = 1'b0;
            default:
                mode_ok = 1'b0;            // codes 0, 6, 7
        endcase
    end

    assign status_hit = (req.addr == mem_map_pkg::STATUS_ADDR);   // full compare, no wrap
    assign access_ok  = req.valid && mode_ok && !misaligned && !status_hit;

    assign ram_we    = access_ok && req.write;
    assign ram_re    = access_ok && !req.write;
    assign ram_index = req.addr[mem_map_pkg::INDEX_LSB +: mem_map_pkg::RAM_INDEX_W];

    assign st_mode   = req.mode;
    assign st_offset = req.addr[1:0];
    assign st_wdata  = req.wdata;

    always_comb
    begin
        ctx_next.valid      = req.valid;
        ctx_next.write      = req.write;
        ctx_next.misaligned = misaligned;
        ctx_next.status_hit = status_hit;
        ctx_next.mode       = req.mode;
        ctx_next.offset     = req.addr[1:0];
        ctx_next.trigger    = trigger;       // status reads see the request cycle
    end

    // the stage's pipeline register
    always_ff @(posedge clk)
    begin
        if (reset)
            ctx <= '0;
        else
            ctx <= ctx_next;
    end

    // every strobe produces exactly one context one cycle later
    a_ctx_follows_req: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (ctx.valid == $past(req.valid)));

    // a write starts only on a live, aligned request
    a_we_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ram_we) |-> req.valid ##1 (ctx.valid && ctx.write && !ctx.misaligned));

endmodule

// File: common/lsu_pkg.sv
package lsu_pkg;

    // access mode as carried on the request
    typedef logic [2:0] mode_t;

    localparam mode_t MODE_WORD   = 3'd1;
    localparam mode_t MODE_HALF   = 3'd2;   // signed for loads
    localparam mode_t MODE_BYTE   = 3'd3;   // signed for loads
    localparam mode_t MODE_HALF_U = 3'd4;
    localparam mode_t MODE_BYTE_U = 3'd5;

    // one access, valid for a single cycle
    typedef struct packed {
        logic               valid;
        logic               write;
        mode_t              mode;
        mem_map_pkg::addr_t addr;
        mem_map_pkg::word_t wdata;
    } mem_req_t;

    // response, one cycle after the request
    typedef struct packed {
        logic               valid;
        logic               write;       // echoed from the request
        logic               misaligned;
        mem_map_pkg::word_t rdata;
    } mem_rsp_t;

    // request context held across the pipeline register
    typedef struct packed {
        logic                               valid;
        logic                               write;
        logic                               misaligned;
        logic                               status_hit;
        mode_t                              mode;
        logic [mem_map_pkg::INDEX_LSB-1:0]  offset;     // byte offset in the word
        logic                               trigger;    // sampled in the request cycle
    } rsp_ctx_t;

endpackage

// File: common/mem_map_pkg.sv
package mem_map_pkg;

    // geometry of the data RAM
    localparam int RAM_INDEX_W    = 15;                 // word index bits
    localparam int RAM_WORDS      = 2 ** RAM_INDEX_W;   // 32768 words, 128 KiB
    localparam int BYTES_PER_WORD = 4;
    localparam int INDEX_LSB      = 2;                  // address bits below the word index

    // byte address as seen on the request
    typedef logic [31:0] addr_t;

    // one data word, little endian lanes
    typedef logic [31:0] word_t;

    // word index into the RAM, address bits 16..2
    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

    // one enable per byte lane
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // status word, bit 0 returns the trigger input
    localparam addr_t STATUS_ADDR = 32'h0000_0100;

endpackage
